/* hdl/rename_pkg.sv */
// register-file geometry; architectural register 0 always maps to physical register 0.
package rename_pkg;

    // architectural registers seen by the instruction set.
    localparam int NUM_AREGS = 32;

    // physical registers behind the map, entry 0 is never handed out.
    localparam int NUM_PREGS = 64;

    // architectural register index.
    typedef logic [$clog2(NUM_AREGS)-1:0] areg_idx_t;

    // physical register index.
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_idx_t;

    // one extra bit so the count can reach the full register file.
    typedef logic [$clog2(NUM_PREGS):0] free_count_t;

endpackage

/* hdl/rob_pkg.sv */
// reorder-buffer geometry; depth must be a power of two for pointer wrap.
package rob_pkg;

    // entries in flight between rename and commit.
    localparam int ROB_DEPTH = 16;

    // slot index, wraps naturally at the depth.
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy, needs to represent a full buffer.
    typedef logic [$clog2(ROB_DEPTH):0] rob_count_t;

endpackage

/* hdl/commit_if.sv */
// one commit per cycle, no back-pressure; prev_preg is answered combinationally.
`timescale 1ns/1ns

interface commit_if;
    import rename_pkg::*;

    logic      valid;
    areg_idx_t areg;
    preg_idx_t preg;
    // old committed mapping of areg.
    preg_idx_t prev_preg;

    // reorder buffer offers its head entry.
    modport rob (output valid, output areg, output preg);

    // retire map takes the new mapping and reports the old one.
    modport retire (input valid, input areg, input preg, output prev_preg);

    // free list reclaims the displaced register.
    modport reclaim (input valid, input prev_preg);

endinterface

/* hdl/rename_map.sv */
// speculative map; source lookups are combinational and flush restores in one edge.
`timescale 1ns/1ns

module rename_map (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 rename_fire,
    input  rename_pkg::areg_idx_t rename_dest,
    input  rename_pkg::preg_idx_t rename_dest_preg,
    input  rename_pkg::areg_idx_t src1,
    input  rename_pkg::areg_idx_t src2,
    output rename_pkg::preg_idx_t src1_preg,
    output rename_pkg::preg_idx_t src2_preg,
    input  logic                 flush,
    input  rename_pkg::preg_idx_t retired_map [rename_pkg::NUM_AREGS]
);
    import rename_pkg::*;

    preg_idx_t spec_table [NUM_AREGS];

    // lookups see the table before this instruction's own write.
    assign src1_preg = spec_table[src1];
    assign src2_preg = spec_table[src2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                spec_table[i] <= '0;
            end
        end else if (flush) begin
            // throw away every speculative mapping.
            spec_table <= retired_map;
        end else if (rename_fire && (rename_dest != '0)) begin
            spec_table[rename_dest] <= rename_dest_preg;
        end
    end

endmodule

/* hdl/retire_map.sv */
// committed map; entry 0 is never written, so prev_preg for areg 0 is always 0.
`timescale 1ns/1ns

module retire_map (
    input  logic                 clock,
    input  logic                 reset,
    commit_if.retire             commit,
    output rename_pkg::preg_idx_t retired_map [rename_pkg::NUM_AREGS]
);
    import rename_pkg::*;

    preg_idx_t arch_table [NUM_AREGS];

    // the displaced register goes back to the free list.
    assign commit.prev_preg = (commit.areg == '0) ? '0 : arch_table[commit.areg];

    // full copy for flush recovery.
    assign retired_map = arch_table;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                arch_table[i] <= '0;
            end
        end else if (commit.valid && (commit.areg != '0)) begin
            arch_table[commit.areg] <= commit.preg;
        end
    end

endmodule

/* hdl/free_list.sv */
// free register queue; releases only at commit, so flush just rewinds the speculative head.
`timescale 1ns/1ns

module free_list (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alloc,
    output rename_pkg::preg_idx_t   alloc_preg,
    output logic                   has_free,
    commit_if.reclaim              commit,
    input  logic                   commit_alloc,
    input  logic                   flush,
    output rename_pkg::free_count_t free_count
);
    import rename_pkg::*;

    // one slot per physical register, 63 live entries at most.
    preg_idx_t queue [NUM_PREGS];

    // pointers are register-sized and wrap at the queue depth.
    preg_idx_t spec_head;
    preg_idx_t ret_head;
    preg_idx_t tail;
    preg_idx_t occupancy;
    logic      release_fire;

    assign occupancy    = tail - spec_head;
    assign free_count   = free_count_t'(occupancy);
    assign has_free     = (occupancy != '0);
    assign alloc_preg   = queue[spec_head];
    assign release_fire = commit.valid && (commit.prev_preg != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // registers 1 to 63 in order, last slot empty.
            for (int i = 0; i < NUM_PREGS - 1; i++) begin
                queue[i] <= preg_idx_t'(i + 1);
            end
            queue[NUM_PREGS-1] <= '0;
            spec_head <= '0;
            ret_head  <= '0;
            tail      <= preg_idx_t'(NUM_PREGS - 1);
        end else begin
            if (release_fire) begin
                queue[tail] <= commit.prev_preg;
                tail        <= tail + 1'b1;
            end

            // committed allocations follow the same order as renames.
            if (commit_alloc) begin
                ret_head <= ret_head + 1'b1;
            end

            if (flush) begin
                spec_head <= ret_head;
            end else if (alloc) begin
                spec_head <= spec_head + 1'b1;
            end
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
// in-order commit of one entry per cycle; completing an empty slot is not checked here.
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  rename_fire,
    input  rename_pkg::areg_idx_t  rename_dest,
    input  rename_pkg::preg_idx_t  rename_dest_preg,
    output rob_pkg::rob_idx_t      tail_idx,
    output logic                  not_full,
    input  logic                  complete_valid,
    input  rob_pkg::rob_idx_t      complete_rob_idx,
    input  logic                  flush,
    commit_if.rob                 commit
);
    import rename_pkg::*;
    import rob_pkg::*;

    // destination pair of each renamed instruction.
    areg_idx_t entry_areg [ROB_DEPTH];
    preg_idx_t entry_preg [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;

    rob_idx_t   head;
    rob_idx_t   tail;
    rob_count_t count;

    assign tail_idx = tail;
    assign not_full = (count != rob_count_t'(ROB_DEPTH));

    // oldest entry leaves once its result is in.
    assign commit.valid = (count != '0) && done[head] && !flush;
    assign commit.areg  = entry_areg[head];
    assign commit.preg  = entry_preg[head];

    always_ff @(posedge clock) begin
        if (rename_fire) begin
            entry_areg[tail] <= rename_dest;
            entry_preg[tail] <= rename_dest_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (complete_valid) begin
                done[complete_rob_idx] <= 1'b1;
            end
            // a new entry starts out pending.
            if (rename_fire) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (commit.valid) begin
                head <= head + 1'b1;
            end

            if (rename_fire && !commit.valid) begin
                count <= count + 1'b1;
            end else if (!rename_fire && commit.valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hdl/rename_top.sv */
// one rename and at most one commit per cycle; complete and flush come from outside.
`timescale 1ns/1ns

module rename_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   rename_valid,
    input  rename_pkg::areg_idx_t   rename_src1,
    input  rename_pkg::areg_idx_t   rename_src2,
    input  rename_pkg::areg_idx_t   rename_dest,
    output logic                   rename_ready,
    output rename_pkg::preg_idx_t   rename_src1_preg,
    output rename_pkg::preg_idx_t   rename_src2_preg,
    output rename_pkg::preg_idx_t   rename_dest_preg,
    output rob_pkg::rob_idx_t       rename_rob_idx,
    input  logic                   complete_valid,
    input  rob_pkg::rob_idx_t       complete_rob_idx,
    input  logic                   flush,
    output logic                   commit_valid,
    output rename_pkg::areg_idx_t   commit_areg,
    output rename_pkg::preg_idx_t   commit_preg,
    output rename_pkg::preg_idx_t   commit_prev_preg,
    output rename_pkg::free_count_t free_count
);
    import rename_pkg::*;

    commit_if commit_bus ();

    preg_idx_t retired_map [NUM_AREGS];
    preg_idx_t alloc_preg;
    logic      has_free;
    logic      rob_not_full;
    logic      dest_zero;
    logic      rename_fire;
    logic      alloc;
    logic      commit_alloc;

    assign dest_zero = (rename_dest == '0);

    // destination 0 needs no free register.
    assign rename_ready = rob_not_full && (has_free || dest_zero) && !flush;
    assign rename_fire  = rename_valid && rename_ready;
    assign alloc        = rename_fire && !dest_zero;

    assign rename_dest_preg = dest_zero ? '0 : alloc_preg;

    // retired head moves only for commits that took a register.
    assign commit_alloc = commit_bus.valid && (commit_bus.areg != '0);

    assign commit_valid     = commit_bus.valid;
    assign commit_areg      = commit_bus.areg;
    assign commit_preg      = commit_bus.preg;
    assign commit_prev_preg = commit_bus.prev_preg;

    rename_map u_rename_map (
        .clock            (clock),
        .reset            (reset),
        .rename_fire      (rename_fire),
        .rename_dest      (rename_dest),
        .rename_dest_preg (rename_dest_preg),
        .src1             (rename_src1),
        .src2             (rename_src2),
        .src1_preg        (rename_src1_preg),
        .src2_preg        (rename_src2_preg),
        .flush            (flush),
        .retired_map      (retired_map)
    );

    retire_map u_retire_map (
        .clock       (clock),
        .reset       (reset),
        .commit      (commit_bus.retire),
        .retired_map (retired_map)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_preg   (alloc_preg),
        .has_free     (has_free),
        .commit       (commit_bus.reclaim),
        .commit_alloc (commit_alloc),
        .flush        (flush),
        .free_count   (free_count)
    );

    reorder_buffer u_reorder_buffer (
        .clock            (clock),
        .reset            (reset),
        .rename_fire      (rename_fire),
        .rename_dest      (rename_dest),
        .rename_dest_preg (rename_dest_preg),
        .tail_idx         (rename_rob_idx),
        .not_full         (rob_not_full),
        .complete_valid   (complete_valid),
        .complete_rob_idx (complete_rob_idx),
        .flush            (flush),
        .commit           (commit_bus.rob)
    );

endmodule

/* sim/rename_assertions.sv */
// shadow checker bound into rename_top; assumes completions only target outstanding entries.
`timescale 1ns/1ns

module rename_assertions (
    input logic                   clock,
    input logic                   reset,
    input logic                   rename_valid,
    input rename_pkg::areg_idx_t   rename_src1,
    input rename_pkg::areg_idx_t   rename_src2,
    input rename_pkg::areg_idx_t   rename_dest,
    input logic                   rename_ready,
    input rename_pkg::preg_idx_t   rename_src1_preg,
    input rename_pkg::preg_idx_t   rename_src2_preg,
    input rename_pkg::preg_idx_t   rename_dest_preg,
    input rob_pkg::rob_idx_t       rename_rob_idx,
    input logic                   complete_valid,
    input rob_pkg::rob_idx_t       complete_rob_idx,
    input logic                   flush,
    input logic                   commit_valid,
    input rename_pkg::areg_idx_t   commit_areg,
    input rename_pkg::preg_idx_t   commit_preg,
    input rename_pkg::preg_idx_t   commit_prev_preg,
    input rename_pkg::free_count_t free_count
);
    import rename_pkg::*;
    import rob_pkg::*;

    // raised by any failing assertion.
    logic failed = 1'b0;

    preg_idx_t            spec_map [NUM_AREGS];
    preg_idx_t            ret_map [NUM_AREGS];
    areg_idx_t            q_areg [ROB_DEPTH];
    preg_idx_t            q_preg [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] q_done;
    rob_idx_t             q_head;
    rob_idx_t             q_tail;
    rob_count_t           q_count;
    free_count_t          shadow_free;
    free_count_t          ret_in_use;
    logic [NUM_PREGS-1:0] used;
    logic                 dest_in_use;
    logic                 fire;
    logic                 release_fire;

    assign fire         = rename_valid && rename_ready;
    assign q_tail       = q_head + rob_idx_t'(q_count);
    assign release_fire = commit_valid && (ret_map[q_areg[q_head]] != '0);

    // distinct retired registers and whether the new register is already mapped.
    always_comb begin
        used        = '0;
        dest_in_use = 1'b0;
        ret_in_use  = '0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            used[ret_map[i]] = 1'b1;
            if (spec_map[i] == rename_dest_preg) begin
                dest_in_use = 1'b1;
            end
        end
        for (int p = 1; p < NUM_PREGS; p++) begin
            ret_in_use = ret_in_use + free_count_t'(used[p]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                spec_map[i] <= '0;
                ret_map[i]  <= '0;
            end
            q_head      <= '0;
            q_count     <= '0;
            q_done      <= '0;
            shadow_free <= free_count_t'(NUM_PREGS - 1);
        end else if (flush) begin
            spec_map    <= ret_map;
            q_head      <= '0;
            q_count     <= '0;
            q_done      <= '0;
            shadow_free <= free_count_t'(NUM_PREGS - 1) - ret_in_use;
        end else begin
            if (complete_valid) begin
                q_done[complete_rob_idx] <= 1'b1;
            end
            if (fire) begin
                q_areg[q_tail] <= rename_dest;
                q_preg[q_tail] <= rename_dest_preg;
                q_done[q_tail] <= 1'b0;
                if (rename_dest != '0) begin
                    spec_map[rename_dest] <= rename_dest_preg;
                end
            end
            if (commit_valid) begin
                if (q_areg[q_head] != '0) begin
                    ret_map[q_areg[q_head]] <= q_preg[q_head];
                end
                q_head <= q_head + 1'b1;
            end
            q_count     <= q_count + rob_count_t'(fire) - rob_count_t'(commit_valid);
            shadow_free <= shadow_free + free_count_t'(release_fire)
                           - free_count_t'(fire && (rename_dest != '0));
        end
    end

    a_reset_state: assert property (@(posedge clock) $fell(reset) |->
        rename_ready && (free_count == free_count_t'(NUM_PREGS - 1)) && !commit_valid
        && (rename_src1_preg == '0) && (rename_src2_preg == '0))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: state one cycle after reset", $time);
    end

    a_rename_src: assert property (@(posedge clock) disable iff (reset) fire |->
        (rename_src1_preg == spec_map[rename_src1])
        && (rename_src2_preg == spec_map[rename_src2]))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: source lookup differs from speculative map", $time);
    end

    // a fresh register must be nonzero and unmapped; destination 0 gets 0.
    a_rename_dest: assert property (@(posedge clock) disable iff (reset) fire |->
        ((rename_dest == '0) ? (rename_dest_preg == '0)
                             : ((rename_dest_preg != '0) && !dest_in_use))
        && (rename_rob_idx == q_tail))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: destination register or ROB index", $time);
    end

    a_commit_ready: assert property (@(posedge clock) disable iff (reset) commit_valid |->
        (q_count != '0) && q_done[q_head])
    else begin
        failed = 1'b1;
        $error("commit offered while the oldest entry is not completed");
    end

    // a completed oldest entry must leave unless a flush is in progress.
    a_commit_offer: assert property (@(posedge clock) disable iff (reset)
        ((q_count != '0) && q_done[q_head] && !flush) |-> commit_valid)
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: oldest entry is completed but commit_valid is low", $time);
    end

    a_commit_data: assert property (@(posedge clock) disable iff (reset) commit_valid |->
        (commit_areg == q_areg[q_head]) && (commit_preg == q_preg[q_head])
        && (commit_prev_preg == ret_map[q_areg[q_head]]))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: commit differs from oldest renamed entry", $time);
    end

    a_free_count: assert property (@(posedge clock) disable iff (reset)
        free_count == shadow_free)
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: free_count %0d, expected %0d", $time, free_count, shadow_free);
    end

    a_flush_restore: assert property (@(posedge clock) disable iff (reset) flush |=>
        (rename_src1_preg == ret_map[rename_src1])
        && (rename_src2_preg == ret_map[rename_src2])
        && (free_count == free_count_t'(NUM_PREGS - 1) - ret_in_use))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: state after flush differs from retired map", $time);
    end

    a_ready: assert property (@(posedge clock) disable iff (reset)
        rename_ready == !((q_count == ROB_DEPTH)
                          || ((shadow_free == '0) && (rename_dest != '0)) || flush))
    else begin
        failed = 1'b1;
        $error("Mismatch at %0t: rename_ready is %0b", $time, rename_ready);
    end

endmodule

bind rename_top rename_assertions u_assertions (.*);

/* sim/tb_rename_top.sv */
// random stimulus only; results are judged by the bound checker instance u_assertions.
`timescale 1ns/1ns

module tb_rename_top;
    import rename_pkg::*;
    import rob_pkg::*;

    localparam int NUM_OPS     = 600;
    localparam int BURST_START = 400;
    localparam int DRAIN_START = 460;
    // three cycles per operation covers every phase with margin.
    localparam int MAX_CYCLES  = 3 * NUM_OPS + 200;

    logic        clock = 1'b0;
    logic        reset;
    logic        rename_valid;
    areg_idx_t   rename_src1;
    areg_idx_t   rename_src2;
    areg_idx_t   rename_dest;
    logic        rename_ready;
    preg_idx_t   rename_src1_preg;
    preg_idx_t   rename_src2_preg;
    preg_idx_t   rename_dest_preg;
    rob_idx_t    rename_rob_idx;
    logic        complete_valid;
    rob_idx_t    complete_rob_idx;
    logic        flush;
    logic        commit_valid;
    areg_idx_t   commit_areg;
    preg_idx_t   commit_preg;
    preg_idx_t   commit_prev_preg;
    free_count_t free_count;

    logic [31:0]          rand_state = 32'h18a2;
    // renamed entries that have not been completed yet.
    logic [ROB_DEPTH-1:0] pending;
    logic                 running = 1'b0;
    int                   op_count = 0;
    int                   cycle_count = 0;

    rename_top uut (
        .clock            (clock),
        .reset            (reset),
        .rename_valid     (rename_valid),
        .rename_src1      (rename_src1),
        .rename_src2      (rename_src2),
        .rename_dest      (rename_dest),
        .rename_ready     (rename_ready),
        .rename_src1_preg (rename_src1_preg),
        .rename_src2_preg (rename_src2_preg),
        .rename_dest_preg (rename_dest_preg),
        .rename_rob_idx   (rename_rob_idx),
        .complete_valid   (complete_valid),
        .complete_rob_idx (complete_rob_idx),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_areg      (commit_areg),
        .commit_preg      (commit_preg),
        .commit_prev_preg (commit_prev_preg),
        .free_count       (free_count)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clock) begin : stimulus
        logic [31:0] r;
        logic        want;
        logic        found;
        rob_idx_t    slot;
        if (running && (op_count < NUM_OPS)) begin
            // follow what the DUT took on this edge.
            if (flush) begin
                pending = '0;
            end else if (rename_valid && rename_ready) begin
                pending[rename_rob_idx] = 1'b1;
            end
            rand_state = xorshift(rand_state);
            r = rand_state;
            rename_valid <= (op_count >= BURST_START) || (r[1:0] != 2'b00);
            rename_src1  <= areg_idx_t'(r[6:2]);
            rename_src2  <= areg_idx_t'(r[11:7]);
            // later phases always need a register.
            if ((op_count >= BURST_START) && (r[16:12] == 5'd0)) begin
                rename_dest <= areg_idx_t'(1);
            end else begin
                rename_dest <= areg_idx_t'(r[16:12]);
            end
            flush <= (op_count < BURST_START) && (r[22:17] == 6'd0);
            // no completions in the burst and only rare ones while draining.
            want  = (op_count < BURST_START) ? r[27]
                                             : ((op_count >= DRAIN_START) && (r[30:28] == 3'd0));
            found = 1'b0;
            if (want) begin
                for (int k = 0; k < ROB_DEPTH; k++) begin
                    slot = rob_idx_t'(r[26:23] + k);
                    if (!found && pending[slot]) begin
                        found            = 1'b1;
                        pending[slot]    = 1'b0;
                        complete_rob_idx <= slot;
                    end
                end
            end
            complete_valid <= found;
            op_count       <= op_count + 1;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("STATUS: FAIL");
            $fatal(1, "timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    always @(posedge uut.u_assertions.failed) begin
        $display("STATUS: FAIL");
        $fatal(1, "an assertion in the bound checker failed");
    end

    initial begin
        reset            = 1'b1;
        rename_valid     = 1'b0;
        // nonzero sources so the lookups after reset read real table entries.
        rename_src1      = areg_idx_t'(NUM_AREGS - 1);
        rename_src2      = areg_idx_t'(1);
        rename_dest      = '0;
        complete_valid   = 1'b0;
        complete_rob_idx = '0;
        flush            = 1'b0;
        pending          = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        running <= 1'b1;
        while (op_count < NUM_OPS) begin
            @(posedge clock);
        end
        rename_valid   <= 1'b0;
        complete_valid <= 1'b0;
        flush          <= 1'b0;
        repeat (4) @(posedge clock);
        if (uut.u_assertions.failed) begin
            $display("STATUS: FAIL");
            $fatal(1, "an assertion failure was seen during the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* rename_top.f */
hdl/rename_pkg.sv
hdl/rob_pkg.sv
hdl/commit_if.sv
hdl/rename_map.sv
hdl/retire_map.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/rename_top.sv
sim/rename_assertions.sv
sim/tb_rename_top.sv
